// File: build.f
+incdir+include
hw/dadda_pkg.sv
hw/pipe_reg.sv
hw/pp_gen_stage.sv
hw/dadda_reduce_stage.sv
hw/cla_adder_stage.sv
hw/dadda_mult_top.sv
tests/tb_dadda_mult.sv

// File: hw/cla_adder_stage.sv
////////////////////////////////////////////////////////////
// Final stage: adds the two rows left by the reduction with a
// two-level carry-lookahead adder and registers the product.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module cla_adder_stage
    import dadda_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  pp_matrix_t in_matrix,
    output logic       out_valid,
    input  logic       out_ready,
    output product_t   product
);

    localparam int GRP    = `DADDA_CLA_GROUP;
    localparam int GROUPS = `DADDA_PRODUCT_WIDTH / `DADDA_CLA_GROUP;

    product_t          row_x;
    product_t          row_y;
    product_t          g;
    product_t          p;
    product_t          carry;
    product_t          sum;
    logic [GROUPS-1:0] grp_g;
    logic [GROUPS-1:0] grp_p;
    logic [GROUPS-1:0] grp_c;

    // carry into position hi, flattened sum of products from position lo
    function automatic logic la_carry(input product_t gv, input product_t pv,
                                      input logic cin, input int lo, input int hi);
        logic c;
        logic term;
        c = cin;
        for (int m = lo; m < hi; m++)
        begin
            c = c & pv[m];
        end
        for (int j = lo; j < hi; j++)
        begin
            term = gv[j];
            for (int m = j + 1; m < hi; m++)
            begin
                term = term & pv[m];
            end
            c = c | term;
        end
        return c;
    endfunction

    assign row_x = in_matrix[0];
    assign row_y = in_matrix[1];
    assign g     = row_x & row_y;
    assign p     = row_x ^ row_y;

    always_comb
    begin
        // group generate and propagate
        for (int k = 0; k < GROUPS; k++)
        begin
            grp_g[k] = la_carry(g, p, 1'b0, k * GRP, (k + 1) * GRP);
            grp_p[k] = &p[k * GRP +: GRP];
        end
        // lookahead across groups
        for (int k = 0; k < GROUPS; k++)
        begin
            grp_c[k] = la_carry(product_t'(grp_g), product_t'(grp_p), 1'b0, 0, k);
        end
        for (int i = 0; i < `DADDA_PRODUCT_WIDTH; i++)
        begin
            carry[i] = la_carry(g, p, grp_c[i / GRP], (i / GRP) * GRP, i);
        end
        sum = p ^ carry;
    end

    pipe_reg #(
        .payload_t (product_t)
    ) u_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (sum),
        .m_valid (out_valid),
        .m_ready (out_ready),
        .m_data  (product)
    );

endmodule

// File: hw/dadda_mult_top.sv
////////////////////////////////////////////////////////////
// Pipelined 16x16 unsigned Dadda multiplier, five cycles deep.
// Operands in and products out over valid/ready streams.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module dadda_mult_top
    import dadda_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    input  logic     out_ready,
    output product_t product
);

    logic       m0_valid;
    logic       m0_ready;
    pp_matrix_t m0;
    logic       m1_valid;
    logic       m1_ready;
    pp_matrix_t m1;
    logic       m2_valid;
    logic       m2_ready;
    pp_matrix_t m2;
    logic       m3_valid;
    logic       m3_ready;
    pp_matrix_t m3;

    pp_gen_stage u_pp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .out_valid (m0_valid),
        .out_ready (m0_ready),
        .matrix    (m0)
    );

    // 16 -> 12
    dadda_reduce_stage #(
        .IN_HEIGHT  (`DADDA_PP_HEIGHT),
        .OUT_HEIGHT (`DADDA_L1_HEIGHT)
    ) u_red1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (m0_valid),
        .in_ready   (m0_ready),
        .in_matrix  (m0),
        .out_valid  (m1_valid),
        .out_ready  (m1_ready),
        .out_matrix (m1)
    );

    // 12 -> 5
    dadda_reduce_stage #(
        .IN_HEIGHT  (`DADDA_L1_HEIGHT),
        .OUT_HEIGHT (`DADDA_L2_HEIGHT)
    ) u_red2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (m1_valid),
        .in_ready   (m1_ready),
        .in_matrix  (m1),
        .out_valid  (m2_valid),
        .out_ready  (m2_ready),
        .out_matrix (m2)
    );

    // 5 -> 2
    dadda_reduce_stage #(
        .IN_HEIGHT  (`DADDA_L2_HEIGHT),
        .OUT_HEIGHT (`DADDA_L3_HEIGHT)
    ) u_red3 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (m2_valid),
        .in_ready   (m2_ready),
        .in_matrix  (m2),
        .out_valid  (m3_valid),
        .out_ready  (m3_ready),
        .out_matrix (m3)
    );

    cla_adder_stage u_cla (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (m3_valid),
        .in_ready  (m3_ready),
        .in_matrix (m3),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .product   (product)
    );

endmodule

// File: hw/dadda_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the Dadda multiplier pipeline.
// Stages pull these in by a wildcard import.
////////////////////////////////////////////////////////////
`include "dadda_defines.svh"

package dadda_pkg;

    // one unsigned operand
    typedef logic [`DADDA_OPERAND_WIDTH-1:0] operand_t;

    // full-width unsigned product
    typedef logic [`DADDA_PRODUCT_WIDTH-1:0] product_t;

    // bit matrix indexed [row][column]
    // every column is packed toward row 0, unused rows stay zero
    typedef logic [`DADDA_PP_HEIGHT-1:0][`DADDA_PRODUCT_WIDTH-1:0] pp_matrix_t;

    // both multiplier inputs side by side
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

endpackage

// File: hw/dadda_reduce_stage.sv
////////////////////////////////////////////////////////////
// One reduction stage: walks the matrix down the Dadda heights
// from IN_HEIGHT to OUT_HEIGHT with 3:2 and 2:2 counters.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module dadda_reduce_stage
    import dadda_pkg::*;
#(
    parameter int IN_HEIGHT  = 16,
    parameter int OUT_HEIGHT = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  pp_matrix_t in_matrix,
    output logic       out_valid,
    input  logic       out_ready,
    output pp_matrix_t out_matrix
);

    pp_matrix_t reduced;

    // true for 2, 3, 4, 6, 9, 13, ...
    function automatic logic is_dadda(input int n);
        int d;
        d = 2;
        for (int k = 0; k < `DADDA_PP_HEIGHT; k++)
        begin
            if (d < n)
            begin
                d = (d * 3) / 2;
            end
        end
        return d == n;
    endfunction

    // one counter level from height h to height t
    // sums stay in the column, carries go one column up
    function automatic pp_matrix_t reduce_level(input pp_matrix_t m, input int h, input int t);
        pp_matrix_t                 r;
        logic [`DADDA_PP_HEIGHT-1:0] cin_bits;
        logic [`DADDA_PP_HEIGHT-1:0] cout_bits;
        int                         n_cin;
        int                         n_cout;
        int                         need;
        int                         n_fa;
        int                         n_ha;
        int                         src;
        int                         dst;
        logic                       x;
        logic                       y;
        logic                       z;
        r        = '0;
        cin_bits = '0;
        n_cin    = 0;
        for (int col = 0; col < `DADDA_PRODUCT_WIDTH; col++)
        begin
            // incoming carries count toward this column's height
            need = h + n_cin - t;
            if (need < 0)
            begin
                need = 0;
            end
            n_fa      = need / 2;
            n_ha      = need % 2;
            src       = 0;
            dst       = 0;
            n_cout    = 0;
            cout_bits = '0;
            for (int k = 0; k < `DADDA_PP_HEIGHT; k++)
            begin
                if (k < n_fa)
                begin
                    x = m[src][col];
                    y = m[src + 1][col];
                    z = m[src + 2][col];
                    r[dst][col]       = x ^ y ^ z;
                    cout_bits[n_cout] = (x & y) | (x & z) | (y & z);
                    src    = src + 3;
                    dst    = dst + 1;
                    n_cout = n_cout + 1;
                end
            end
            if (n_ha != 0)
            begin
                x = m[src][col];
                y = m[src + 1][col];
                r[dst][col]       = x ^ y;
                cout_bits[n_cout] = x & y;
                src    = src + 2;
                dst    = dst + 1;
                n_cout = n_cout + 1;
            end
            // untouched bits, then carries from below, packed on top
            for (int k = 0; k < `DADDA_PP_HEIGHT; k++)
            begin
                if (k >= src && k < h)
                begin
                    r[dst][col] = m[k][col];
                    dst = dst + 1;
                end
            end
            for (int k = 0; k < `DADDA_PP_HEIGHT; k++)
            begin
                if (k < n_cin)
                begin
                    r[dst][col] = cin_bits[k];
                    dst = dst + 1;
                end
            end
            cin_bits = cout_bits;
            n_cin    = n_cout;
        end
        return r;
    endfunction

    always_comb
    begin
        pp_matrix_t work;
        int         h;
        work = in_matrix;
        h    = IN_HEIGHT;
        for (int t = IN_HEIGHT - 1; t >= OUT_HEIGHT; t--)
        begin
            if (t == OUT_HEIGHT || is_dadda(t))
            begin
                work = reduce_level(work, h, t);
                h    = t;
            end
        end
        reduced = work;
    end

    pipe_reg #(
        .payload_t (pp_matrix_t)
    ) u_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (reduced),
        .m_valid (out_valid),
        .m_ready (out_ready),
        .m_data  (out_matrix)
    );

endmodule

// File: hw/pipe_reg.sv
////////////////////////////////////////////////////////////
// Single-entry valid/ready register slice.
// Payload type is chosen per instance; every pipeline stage ends in one.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);

    logic     valid_q;
    payload_t data_q;

    // room when empty or when the held item leaves this cycle
    assign s_ready = !valid_q || m_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (s_ready)
        begin
            valid_q <= s_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s_valid && s_ready)
        begin
            data_q <= s_data;
        end
    end

    assign m_valid = valid_q;
    assign m_data  = data_q;

endmodule

// File: hw/pp_gen_stage.sv
////////////////////////////////////////////////////////////
// First pipeline stage: ANDs the operands into a column-aligned
// partial-product matrix and registers it.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module pp_gen_stage
    import dadda_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  operand_t   a,
    input  operand_t   b,
    output logic       out_valid,
    input  logic       out_ready,
    output pp_matrix_t matrix
);

    operand_pair_t ops;
    pp_matrix_t    pp;

    assign ops = '{a: a, b: b};

    // bit j of a times bit i of b lands in column i+j
    always_comb
    begin
        int col;
        int row;
        pp = '0;
        for (int i = 0; i < `DADDA_OPERAND_WIDTH; i++)
        begin
            for (int j = 0; j < `DADDA_OPERAND_WIDTH; j++)
            begin
                col = i + j;
                // upper columns start at a higher b bit, shift them down to row 0
                if (col >= `DADDA_OPERAND_WIDTH)
                begin
                    row = i - (col - (`DADDA_OPERAND_WIDTH - 1));
                end
                else
                begin
                    row = i;
                end
                pp[row][col] = ops.b[i] & ops.a[j];
            end
        end
    end

    pipe_reg #(
        .payload_t (pp_matrix_t)
    ) u_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (pp),
        .m_valid (out_valid),
        .m_ready (out_ready),
        .m_data  (matrix)
    );

endmodule

// File: include/dadda_defines.svh
////////////////////////////////////////////////////////////
// Widths and stage heights for the pipelined Dadda multiplier.
// Include this wherever the matrix shape or adder grouping is needed.
////////////////////////////////////////////////////////////
`ifndef DADDA_DEFINES_SVH
`define DADDA_DEFINES_SVH

// operand and product widths
`define DADDA_OPERAND_WIDTH 16
`define DADDA_PRODUCT_WIDTH 32

// rows in the initial partial-product matrix
`define DADDA_PP_HEIGHT 16

// target heights after each reduction stage
`define DADDA_L1_HEIGHT 12
`define DADDA_L2_HEIGHT 5
`define DADDA_L3_HEIGHT 2

// bits per carry-lookahead group
`define DADDA_CLA_GROUP 4

`endif

// File: run.sh
#!/bin/sh
# builds and runs the Dadda multiplier testbench with Verilator
# the log is searched for the fail message, a failed build or run counts as failure

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_dadda_mult \
    -o tb_dadda_mult > "$LOG" 2>&1 \
    && ./obj_dir/tb_dadda_mult >> "$LOG" 2>&1 \
    || echo "TESTBENCH FAILED" >> "$LOG"

cat "$LOG"
grep -q "TESTBENCH FAILED" "$LOG" && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: tests/tb_dadda_mult.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the pipelined Dadda multiplier.
// Streams operands, models the product and compares every output.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "dadda_defines.svh"

module tb_dadda_mult
    import dadda_pkg::*;
();

    localparam int LATENCY    = 5;
    localparam int WAIT_LIMIT = 100;
    localparam int FILL_LIMIT = 20;
    localparam int N_STREAM   = 200;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    operand_t a;
    operand_t b;
    logic     out_valid;
    logic     out_ready = 1'b0;
    product_t product;

    integer   seed = 14097;
    string    test_name = "reset";
    product_t expected_q[$];
    product_t exp_product;
    product_t held_product;
    logic     held_valid = 1'b0;
    logic     ready_random = 1'b0;
    // out_ready stays low through reset
    logic     ready_level = 1'b0;
    logic     ready_draw = 1'b0;

    dadda_mult_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .product   (product)
    );

    always #10 clk = ~clk;

    // unsigned product straight from the operands
    function automatic product_t mult_ref(input operand_t x, input operand_t y);
        return product_t'(x) * product_t'(y);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_product(input string name, input product_t expected,
                                 input product_t actual);
        if (expected !== actual)
        begin
            abort_run($sformatf("ERROR %s: expected 0x%08h actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            abort_run($sformatf("ERROR %s: expected %b actual %b", name, expected, actual));
        end
    endtask

    // holds the offered pair until the DUT takes it, returns on that edge
    task automatic wait_accept(input operand_t op_a, input operand_t op_b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                abort_run("in_ready never came back for an offered operand pair");
            end
            @(negedge clk);
        end
        expected_q.push_back(mult_ref(op_a, op_b));
        @(posedge clk);
    endtask

    task automatic send_pair(input operand_t op_a, input operand_t op_b);
        in_valid <= 1'b1;
        a        <= op_a;
        b        <= op_b;
        wait_accept(op_a, op_b);
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (expected_q.size() != 0)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT * 2)
            begin
                abort_run("the pipeline never delivered all expected products");
            end
        end
        @(posedge clk);
    endtask

    // out_ready low until the DUT refuses input, then release
    task automatic fill_pipeline();
        operand_t op_a;
        operand_t op_b;
        int       accepted;
        logic     full;
        ready_level = 1'b0;
        accepted    = 0;
        full        = 1'b0;
        op_a        = '0;
        op_b        = '0;
        while (!full)
        begin
            op_a = operand_t'($random(seed));
            op_b = operand_t'($random(seed));
            in_valid <= 1'b1;
            a        <= op_a;
            b        <= op_b;
            @(negedge clk);
            if (in_ready)
            begin
                expected_q.push_back(mult_ref(op_a, op_b));
                accepted++;
                if (accepted > FILL_LIMIT)
                begin
                    abort_run("in_ready never fell while out_ready was held low");
                end
            end
            else
            begin
                full = 1'b1;
            end
            @(posedge clk);
        end
        ready_level = 1'b1;
        wait_accept(op_a, op_b);
        in_valid <= 1'b0;
    endtask

    // next out_ready level, drawn away from the stimulus edge
    always @(negedge clk)
    begin
        if (ready_random)
        begin
            ready_draw = ($random(seed) & 1) != 0;
        end
        else
        begin
            ready_draw = ready_level;
        end
    end

    always @(posedge clk)
    begin
        out_ready <= ready_draw;
    end

    // compare on output transfers, and watch stalled outputs stay put
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            held_valid = 1'b0;
        end
        else
        begin
            if (held_valid)
            begin
                check_flag({test_name, " held out_valid"}, 1'b1, out_valid);
                check_product({test_name, " held product"}, held_product, product);
            end
            if (out_valid && out_ready)
            begin
                if (expected_q.size() == 0)
                begin
                    abort_run("an output transfer came with no product expected");
                end
                else
                begin
                    exp_product = expected_q.pop_front();
                    check_product(test_name, exp_product, product);
                end
            end
            held_valid   = out_valid && !out_ready;
            held_product = product;
        end
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // with out_ready low, in_ready needs every valid cleared
        @(negedge clk);
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset in_ready", 1'b1, in_ready);
        @(posedge clk);
        ready_level = 1'b1;

        test_name = "corner";
        for (int k = 0; k < 8; k++)
        begin
            send_pair('0, operand_t'($random(seed)));
            send_pair(operand_t'($random(seed)), '0);
            send_pair(operand_t'(1), operand_t'($random(seed)));
            send_pair(operand_t'($random(seed)), operand_t'(1));
        end
        send_pair('1, '1);
        for (int i = 0; i < `DADDA_OPERAND_WIDTH; i++)
        begin
            for (int j = 0; j < `DADDA_OPERAND_WIDTH; j++)
            begin
                send_pair(operand_t'(1) << i, operand_t'(1) << j);
            end
        end
        in_valid <= 1'b0;
        drain_outputs();

        // one item through an empty pipeline
        test_name = "latency";
        send_pair(operand_t'(16'hbeef), operand_t'(16'h1234));
        in_valid <= 1'b0;
        for (int n = 1; n <= LATENCY; n++)
        begin
            @(negedge clk);
            check_flag($sformatf("latency cycle %0d out_valid", n), n == LATENCY, out_valid);
            @(posedge clk);
        end
        drain_outputs();

        test_name = "streaming";
        for (int k = 0; k < N_STREAM; k++)
        begin
            send_pair(operand_t'($random(seed)), operand_t'($random(seed)));
        end
        in_valid <= 1'b0;
        drain_outputs();

        test_name    = "back_pressure";
        ready_random = 1'b1;
        for (int k = 0; k < N_STREAM; k++)
        begin
            send_pair(operand_t'($random(seed)), operand_t'($random(seed)));
        end
        in_valid <= 1'b0;
        ready_random = 1'b0;
        ready_level  = 1'b1;
        drain_outputs();

        test_name = "full_pipeline";
        fill_pipeline();
        drain_outputs();

        if (expected_q.size() == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("%0d expected products never came out", expected_q.size());
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
